//--- design/soc_pkg.sv
/*
 * address map, register offsets and bus widths
 * device select type shared by decode and response logic
 */
package soc_pkg;

  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int RAM_AW    = 10;
  localparam int REG_OFF_W = 5;

  // 4 KiB regions picked by the top address nibble
  localparam int REGION_LSB = 12;

  localparam logic [ADDR_W-1:0] RAM_BASE   = 16'h0000;
  localparam logic [ADDR_W-1:0] GPIO_BASE  = 16'h1000;
  localparam logic [ADDR_W-1:0] TIMER_BASE = 16'h2000;

  // gpio register offsets
  localparam logic [REG_OFF_W-1:0] GPIO_DATA_OUT   = 5'h00;
  localparam logic [REG_OFF_W-1:0] GPIO_DIR        = 5'h04;
  localparam logic [REG_OFF_W-1:0] GPIO_DATA_IN    = 5'h08;
  localparam logic [REG_OFF_W-1:0] GPIO_INTR_EN    = 5'h0C;
  localparam logic [REG_OFF_W-1:0] GPIO_INTR_STATE = 5'h10;

  // timer register offsets
  localparam logic [REG_OFF_W-1:0] TIMER_MTIME      = 5'h00;
  localparam logic [REG_OFF_W-1:0] TIMER_CMP        = 5'h04;
  localparam logic [REG_OFF_W-1:0] TIMER_CTRL       = 5'h08;
  localparam logic [REG_OFF_W-1:0] TIMER_INTR_STATE = 5'h0C;

  typedef enum logic [1:0] {DEV_RAM, DEV_GPIO, DEV_TIMER, DEV_NONE} dev_sel_e;

endpackage

//--- design/bus_decode.sv
/*
 * host address decoder
 * per-device request strobes and device select
 */
`timescale 1ns/1ps

module bus_decode (
  input  logic                      req_i,
  input  logic [soc_pkg::ADDR_W-1:0] addr_i,
  output logic                      ram_req_o,
  output logic                      gpio_req_o,
  output logic                      timer_req_o,
  output soc_pkg::dev_sel_e         dev_sel_o
);

  logic [soc_pkg::ADDR_W-soc_pkg::REGION_LSB-1:0] region;

  assign region = addr_i[soc_pkg::ADDR_W-1:soc_pkg::REGION_LSB];

  always_comb begin
    dev_sel_o = soc_pkg::DEV_NONE;
    // word aligned accesses only
    if (addr_i[1:0] == 2'b00) begin
      if (region == soc_pkg::RAM_BASE[soc_pkg::ADDR_W-1:soc_pkg::REGION_LSB]) begin
        dev_sel_o = soc_pkg::DEV_RAM;
      end else if (region == soc_pkg::GPIO_BASE[soc_pkg::ADDR_W-1:soc_pkg::REGION_LSB]) begin
        dev_sel_o = soc_pkg::DEV_GPIO;
      end else if (region == soc_pkg::TIMER_BASE[soc_pkg::ADDR_W-1:soc_pkg::REGION_LSB]) begin
        dev_sel_o = soc_pkg::DEV_TIMER;
      end
    end
  end

  // unmapped or misaligned accesses raise no strobe
  assign ram_req_o   = req_i && (dev_sel_o == soc_pkg::DEV_RAM);
  assign gpio_req_o  = req_i && (dev_sel_o == soc_pkg::DEV_GPIO);
  assign timer_req_o = req_i && (dev_sel_o == soc_pkg::DEV_TIMER);

  // only one device may see any given access
  always_comb begin
    a_one_strobe : assert final ($onehot0({ram_req_o, gpio_req_o, timer_req_o}))
      else $error("more than one device strobe active");
  end

endmodule

//--- design/ram_1p.sv
/*
 * single-port word RAM with per-byte write enables
 * read data registered one cycle after the strobe
 */
`timescale 1ns/1ps

module ram_1p (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [soc_pkg::RAM_AW-1:0]  addr_i,
  input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
  input  logic [soc_pkg::DATA_W/8-1:0] be_i,
  output logic [soc_pkg::DATA_W-1:0]  rdata_o
);

  logic [soc_pkg::DATA_W-1:0] mem [2**soc_pkg::RAM_AW];

  // storage array written one byte lane at a time
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < soc_pkg::DATA_W/8; b++) begin
        if (be_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read port returns zero on a write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- design/gpio_regs.sv
/*
 * GPIO data out, direction and input sampling registers
 * rising-edge interrupt with write-1-clear status
 */
`timescale 1ns/1ps

module gpio_regs (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::REG_OFF_W-1:0] off_i,
  input  logic [soc_pkg::DATA_W-1:0]    wdata_i,
  output logic [soc_pkg::DATA_W-1:0]    rdata_o,
  input  logic [soc_pkg::DATA_W-1:0]    gpio_i,
  output logic [soc_pkg::DATA_W-1:0]    gpio_o,
  output logic [soc_pkg::DATA_W-1:0]    gpio_en_o,
  output logic                          intr_o
);

  logic [soc_pkg::DATA_W-1:0] data_out;
  logic [soc_pkg::DATA_W-1:0] dir;
  logic [soc_pkg::DATA_W-1:0] data_in;
  logic [soc_pkg::DATA_W-1:0] intr_en;
  logic [soc_pkg::DATA_W-1:0] intr_state;
  logic [soc_pkg::DATA_W-1:0] rise;
  logic                       wr;

  assign wr   = req_i && we_i;
  // data_in holds last cycle's pad value
  assign rise = gpio_i & ~data_in;

  // input pads sampled every cycle
  always_ff @(posedge clk_i) begin
    data_in <= gpio_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_out   <= '0;
      dir        <= '0;
      intr_en    <= '0;
      intr_state <= '0;
    end else begin
      if (wr && off_i == soc_pkg::GPIO_DATA_OUT) data_out <= wdata_i;
      if (wr && off_i == soc_pkg::GPIO_DIR) dir <= wdata_i;
      if (wr && off_i == soc_pkg::GPIO_INTR_EN) intr_en <= wdata_i;
      // a new edge wins over a clear in the same cycle
      if (wr && off_i == soc_pkg::GPIO_INTR_STATE) begin
        intr_state <= (intr_state & ~wdata_i) | rise;
      end else begin
        intr_state <= intr_state | rise;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= '0;
      if (!we_i) begin
        case (off_i)
          soc_pkg::GPIO_DATA_OUT:   rdata_o <= data_out;
          soc_pkg::GPIO_DIR:        rdata_o <= dir;
          soc_pkg::GPIO_DATA_IN:    rdata_o <= data_in;
          soc_pkg::GPIO_INTR_EN:    rdata_o <= intr_en;
          soc_pkg::GPIO_INTR_STATE: rdata_o <= intr_state;
          default:                  rdata_o <= '0;
        endcase
      end
    end
  end

  assign gpio_o    = data_out;
  assign gpio_en_o = dir;
  assign intr_o    = |(intr_state & intr_en);

endmodule

//--- design/timer_regs.sv
/*
 * machine timer with free-running mtime, compare and enable
 * sticky expiry interrupt
 */
`timescale 1ns/1ps

module timer_regs (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::REG_OFF_W-1:0] off_i,
  input  logic [soc_pkg::DATA_W-1:0]    wdata_i,
  output logic [soc_pkg::DATA_W-1:0]    rdata_o,
  output logic                          intr_o
);

  logic [soc_pkg::DATA_W-1:0] mtime;
  logic [soc_pkg::DATA_W-1:0] cmp;
  logic                       en;
  logic                       intr_state;
  logic                       wr;
  logic                       mtime_wr;
  logic                       expired;

  assign wr       = req_i && we_i;
  assign mtime_wr = wr && (off_i == soc_pkg::TIMER_MTIME);
  assign expired  = en && (mtime >= cmp);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime      <= '0;
      cmp        <= '1;
      en         <= 1'b0;
      intr_state <= 1'b0;
    end else begin
      // software write takes priority over counting
      if (mtime_wr) begin
        mtime <= wdata_i;
      end else if (en) begin
        mtime <= mtime + 1'b1;
      end
      if (wr && off_i == soc_pkg::TIMER_CMP) cmp <= wdata_i;
      if (wr && off_i == soc_pkg::TIMER_CTRL) en <= wdata_i[0];
      if (wr && off_i == soc_pkg::TIMER_INTR_STATE && wdata_i[0]) begin
        intr_state <= expired;
      end else begin
        intr_state <= intr_state | expired;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= '0;
      if (!we_i) begin
        case (off_i)
          soc_pkg::TIMER_MTIME:      rdata_o <= mtime;
          soc_pkg::TIMER_CMP:        rdata_o <= cmp;
          soc_pkg::TIMER_CTRL:       rdata_o <= {{(soc_pkg::DATA_W-1){1'b0}}, en};
          soc_pkg::TIMER_INTR_STATE: rdata_o <= {{(soc_pkg::DATA_W-1){1'b0}}, intr_state};
          default:                   rdata_o <= '0;
        endcase
      end
    end
  end

  assign intr_o = intr_state;

  // counter frozen while disabled unless software writes it
  a_mtime_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (!en && !mtime_wr) |=> $stable(mtime))
    else $error("mtime moved while timer disabled");

endmodule

//--- design/resp_mux.sv
/*
 * response path with registered select, read data mux and error flag
 */
`timescale 1ns/1ps

module resp_mux (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  soc_pkg::dev_sel_e          dev_sel_i,
  input  logic                       we_i,
  input  logic [soc_pkg::DATA_W-1:0] ram_rdata_i,
  input  logic [soc_pkg::DATA_W-1:0] gpio_rdata_i,
  input  logic [soc_pkg::DATA_W-1:0] timer_rdata_i,
  output logic                       rvalid_o,
  output logic                       err_o,
  output logic [soc_pkg::DATA_W-1:0] rdata_o
);

  logic              req_q;
  logic              we_q;
  soc_pkg::dev_sel_e sel_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  // payload for the access in flight
  always_ff @(posedge clk_i) begin
    we_q  <= we_i;
    sel_q <= dev_sel_i;
  end

  always_comb begin
    rdata_o = '0;
    if (!we_q) begin
      case (sel_q)
        soc_pkg::DEV_RAM:   rdata_o = ram_rdata_i;
        soc_pkg::DEV_GPIO:  rdata_o = gpio_rdata_i;
        soc_pkg::DEV_TIMER: rdata_o = timer_rdata_i;
        default:            rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = req_q;
  assign err_o    = req_q && (sel_q == soc_pkg::DEV_NONE);

  // each request answered exactly one cycle later
  a_rvalid_lat : assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_o == $past(req_i))
    else $error("rvalid_o not aligned to request");

endmodule

//--- design/mini_soc.sv
/*
 * top level with address decode, RAM, GPIO, timer
 * and the response mux behind one strobe-based host port
 */
`timescale 1ns/1ps

module mini_soc (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // host port
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [soc_pkg::ADDR_W-1:0]   addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  input  logic [soc_pkg::DATA_W/8-1:0] be_i,
  output logic                         rvalid_o,
  output logic                         err_o,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  // pads
  input  logic [soc_pkg::DATA_W-1:0]   gpio_i,
  output logic [soc_pkg::DATA_W-1:0]   gpio_o,
  output logic [soc_pkg::DATA_W-1:0]   gpio_en_o,
  // interrupts
  output logic                         intr_gpio_o,
  output logic                         intr_timer_o
);

  logic                          ram_req;
  logic                          gpio_req;
  logic                          timer_req;
  soc_pkg::dev_sel_e             dev_sel;
  logic [soc_pkg::RAM_AW-1:0]    ram_addr;
  logic [soc_pkg::REG_OFF_W-1:0] reg_off;
  logic [soc_pkg::DATA_W-1:0]    ram_rdata;
  logic [soc_pkg::DATA_W-1:0]    gpio_rdata;
  logic [soc_pkg::DATA_W-1:0]    timer_rdata;

  // word address for the RAM, byte offset for the register blocks
  assign ram_addr = addr_i[soc_pkg::RAM_AW+1:2];
  assign reg_off  = addr_i[soc_pkg::REG_OFF_W-1:0];

  bus_decode u_bus_decode (
    .req_i       (req_i),
    .addr_i      (addr_i),
    .ram_req_o   (ram_req),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .dev_sel_o   (dev_sel)
  );

  ram_1p u_ram (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (ram_req),
    .we_i    (we_i),
    .addr_i  (ram_addr),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .rdata_o (ram_rdata)
  );

  gpio_regs u_gpio (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (gpio_req),
    .we_i      (we_i),
    .off_i     (reg_off),
    .wdata_i   (wdata_i),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (intr_gpio_o)
  );

  timer_regs u_timer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (timer_req),
    .we_i    (we_i),
    .off_i   (reg_off),
    .wdata_i (wdata_i),
    .rdata_o (timer_rdata),
    .intr_o  (intr_timer_o)
  );

  resp_mux u_resp_mux (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .dev_sel_i     (dev_sel),
    .we_i          (we_i),
    .ram_rdata_i   (ram_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .rvalid_o      (rvalid_o),
    .err_o         (err_o),
    .rdata_o       (rdata_o)
  );

endmodule

//--- tb/tb_mini_soc.sv
/*
 * testbench with clock, reset and host access tasks
 * reference model of RAM, GPIO and timer plus response checker
 */
`timescale 1ns/1ps

module tb_mini_soc;

  localparam time DRIVE_DLY    = 2ns;
  localparam int  SEED         = 56;
  localparam int  RESP_TIMEOUT = 20;
  localparam int  INTR_TIMEOUT = 200;

  logic        clk_i;
  logic        rst_i;
  logic        req_i;
  logic        we_i;
  logic [15:0] addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  be_i;
  logic        rvalid_o;
  logic        err_o;
  logic [31:0] rdata_o;
  logic [31:0] gpio_i;
  logic [31:0] gpio_o;
  logic [31:0] gpio_en_o;
  logic        intr_gpio_o;
  logic        intr_timer_o;

  // reference model state
  logic [31:0] ram_img [int];
  int          ram_list [$];
  logic [31:0] gm_out;
  logic [31:0] gm_dir;
  logic [31:0] gm_in;
  logic [31:0] gm_ien;
  logic [31:0] gm_ist;
  logic [31:0] tm_cmp;
  logic        tm_ctrl;

  // pending responses in issue order
  logic [31:0] exp_data_q [$];
  logic        exp_err_q [$];
  logic        exp_chk_q [$];
  int          exp_cyc_q [$];
  string       name_q [$];

  int          cyc;
  logic [31:0] last_rdata;
  logic [31:0] got_data;
  logic        got_err;
  logic        got_chk;
  int          got_cyc;
  string       got_name;

  mini_soc mini_soc_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .rvalid_o     (rvalid_o),
    .err_o        (err_o),
    .rdata_o      (rdata_o),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o),
    .intr_gpio_o  (intr_gpio_o),
    .intr_timer_o (intr_timer_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial cyc = 0;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    stop_with_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("CHECK FAILED: %s expected 0x%08h actual 0x%08h", name, exp_v, act_v);
    stop_with_failure();
  endtask

  // expected {checkable, err, rdata} of one access under the address map rules
  function automatic logic [33:0] ref_response(input logic [15:0] addr, input logic we);
    logic [3:0]  region;
    logic [4:0]  off;
    logic [31:0] data;
    logic        chk;
    region = addr[15:12];
    off    = addr[4:0];
    data   = '0;
    chk    = 1'b1;
    if (addr[1:0] != 2'b00 || region > soc_pkg::TIMER_BASE[15:12]) begin
      return {1'b1, 1'b1, 32'h0};
    end
    if (we) begin
      return {1'b1, 1'b0, 32'h0};
    end
    if (region == soc_pkg::RAM_BASE[15:12]) begin
      if (ram_img.exists(addr[11:2])) begin
        data = ram_img[addr[11:2]];
      end else begin
        chk = 1'b0;
      end
    end else if (region == soc_pkg::GPIO_BASE[15:12]) begin
      case (off)
        soc_pkg::GPIO_DATA_OUT:   data = gm_out;
        soc_pkg::GPIO_DIR:        data = gm_dir;
        soc_pkg::GPIO_DATA_IN:    data = gm_in;
        soc_pkg::GPIO_INTR_EN:    data = gm_ien;
        soc_pkg::GPIO_INTR_STATE: data = gm_ist;
        default:                  data = '0;
      endcase
    end else begin
      case (off)
        soc_pkg::TIMER_CMP:  data = tm_cmp;
        soc_pkg::TIMER_CTRL: data = {31'h0, tm_ctrl};
        // counter and expiry state depend on exact cycle timing
        soc_pkg::TIMER_MTIME,
        soc_pkg::TIMER_INTR_STATE: chk = 1'b0;
        default:                   data = '0;
      endcase
    end
    return {chk, 1'b0, data};
  endfunction

  function automatic void update_model(input logic [15:0] addr, input logic [31:0] wdata,
                                       input logic [3:0] be);
    logic [31:0] word_v;
    if (addr[15:12] == soc_pkg::RAM_BASE[15:12]) begin
      word_v = ram_img.exists(addr[11:2]) ? ram_img[addr[11:2]] : 32'h0;
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          word_v[8*b +: 8] = wdata[8*b +: 8];
        end
      end
      ram_img[addr[11:2]] = word_v;
    end else if (addr[15:12] == soc_pkg::GPIO_BASE[15:12]) begin
      case (addr[4:0])
        soc_pkg::GPIO_DATA_OUT:   gm_out = wdata;
        soc_pkg::GPIO_DIR:        gm_dir = wdata;
        soc_pkg::GPIO_INTR_EN:    gm_ien = wdata;
        soc_pkg::GPIO_INTR_STATE: gm_ist = gm_ist & ~wdata;
        default:                  ;
      endcase
    end else begin
      case (addr[4:0])
        soc_pkg::TIMER_CMP:  tm_cmp = wdata;
        soc_pkg::TIMER_CTRL: tm_ctrl = wdata[0];
        default:             ;
      endcase
    end
  endfunction

  // back-to-back calls keep req_i high
  task automatic issue_access(input logic [15:0] addr, input logic we,
                              input logic [31:0] wdata, input logic [3:0] be,
                              input string name);
    logic [33:0] r;
    r       = ref_response(addr, we);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    exp_data_q.push_back(r[31:0]);
    exp_err_q.push_back(r[32]);
    exp_chk_q.push_back(r[33]);
    exp_cyc_q.push_back(cyc);
    name_q.push_back(name);
    if (we && !r[32]) begin
      update_model(addr, wdata, be);
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    req_i = 1'b0;
  endtask

  task automatic wait_responses(input string name);
    int n;
    n = 0;
    while (exp_cyc_q.size() != 0) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      n++;
      assert (n <= RESP_TIMEOUT) else abort_run({name, ": no response before timeout"});
    end
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] be, input string name);
    issue_access(addr, 1'b1, data, be, name);
    wait_responses(name);
  endtask

  task automatic read_word(input logic [15:0] addr, input string name,
                           output logic [31:0] data);
    issue_access(addr, 1'b0, 32'h0, 4'hF, name);
    wait_responses(name);
    data = last_rdata;
  endtask

  // pad change becomes visible in DATA_IN one cycle later
  task automatic drive_pads(input logic [31:0] value);
    gpio_i = value;
    @(posedge clk_i);
    #DRIVE_DLY;
    gm_ist = gm_ist | (value & ~gm_in);
    gm_in  = value;
  endtask

  task automatic wait_interrupt(input bit timer, input logic level, input string name);
    int n;
    n = 0;
    while ((timer ? intr_timer_o : intr_gpio_o) !== level) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      n++;
      assert (n <= INTR_TIMEOUT) else abort_run({name, ": interrupt never reached its level"});
    end
  endtask

  // response checker samples mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (rvalid_o) begin
        assert (exp_cyc_q.size() != 0) else abort_run("response with no request pending");
        got_data = exp_data_q.pop_front();
        got_err  = exp_err_q.pop_front();
        got_chk  = exp_chk_q.pop_front();
        got_cyc  = exp_cyc_q.pop_front();
        got_name = name_q.pop_front();
        assert (cyc == got_cyc + 1) else report_mismatch({got_name, " latency"}, got_cyc + 1, cyc);
        assert (err_o === got_err) else report_mismatch({got_name, " err"}, got_err, err_o);
        if (got_chk) begin
          assert (rdata_o === got_data) else report_mismatch(got_name, got_data, rdata_o);
        end
        last_rdata = rdata_o;
      end else if (exp_cyc_q.size() != 0) begin
        assert (cyc <= exp_cyc_q[0]) else abort_run({name_q[0], ": request got no response"});
      end
    end
  end

  task automatic ram_random_access();
    int          w;
    logic [15:0] a;
    logic [31:0] d;
    for (int i = 0; i < 16; i++) begin
      w = $urandom % 1024;
      a = soc_pkg::RAM_BASE + w * 4;
      ram_list.push_back(w);
      write_word(a, $urandom, 4'hF, "ram full write");
    end
    for (int i = 0; i < 16; i++) begin
      a = soc_pkg::RAM_BASE + ram_list[$urandom % ram_list.size()] * 4;
      write_word(a, $urandom, 4'($urandom), "ram masked write");
    end
    foreach (ram_list[i]) begin
      a = soc_pkg::RAM_BASE + ram_list[i] * 4;
      read_word(a, "ram readback", d);
    end
  endtask

  task automatic burst_in_order();
    logic [15:0] a;
    for (int i = 0; i < 12; i++) begin
      a = soc_pkg::RAM_BASE + ram_list[$urandom % ram_list.size()] * 4;
      issue_access(a, 1'($urandom), $urandom, 4'($urandom), "burst access");
    end
    wait_responses("burst");
  endtask

  task automatic error_responses();
    logic [15:0] a;
    logic [15:0] bad;
    logic [31:0] d;
    a = soc_pkg::RAM_BASE + ram_list[0] * 4;
    write_word(a + 16'd2, $urandom, 4'hF, "misaligned write");
    read_word(a + 16'd1, "misaligned read", d);
    // unmapped regions that alias the same RAM word
    for (int i = 0; i < 4; i++) begin
      bad = {4'(3 + $urandom % 13), a[11:0]};
      write_word(bad, $urandom, 4'hF, "unmapped write");
      read_word(bad, "unmapped read", d);
    end
    read_word(a, "ram after error", d);
  endtask

  task automatic gpio_pads_and_intr();
    logic [31:0] d;
    write_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_DATA_OUT, $urandom, 4'h0, "gpio out");
    write_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_DIR, $urandom, 4'h0, "gpio dir");
    assert (gpio_o === gm_out) else report_mismatch("gpio_o pads", gm_out, gpio_o);
    assert (gpio_en_o === gm_dir) else report_mismatch("gpio_en_o pads", gm_dir, gpio_en_o);
    read_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_DATA_OUT, "gpio out read", d);
    read_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_DIR, "gpio dir read", d);
    drive_pads($urandom);
    read_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_DATA_IN, "gpio in read", d);
    // quiet pads and a clean status before enabling bit 3
    drive_pads(32'h0);
    write_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_INTR_STATE, 32'hFFFF_FFFF, 4'hF, "gpio clr");
    write_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_INTR_EN, 32'h8, 4'hF, "gpio intr en");
    assert (intr_gpio_o === 1'b0) else report_mismatch("gpio intr idle", 0, intr_gpio_o);
    drive_pads(32'h8);
    wait_interrupt(1'b0, 1'b1, "gpio edge interrupt");
    read_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_INTR_STATE, "gpio intr state", d);
    write_word(soc_pkg::GPIO_BASE + soc_pkg::GPIO_INTR_STATE, 32'h8, 4'hF, "gpio w1c");
    wait_interrupt(1'b0, 1'b0, "gpio interrupt clear");
  endtask

  task automatic timer_count_and_intr();
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] d;
    write_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_CTRL, 32'h1, 4'hF, "timer enable");
    read_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_MTIME, "mtime first", t0);
    read_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_MTIME, "mtime second", t1);
    assert (t1 > t0) else report_mismatch("mtime increasing", t0 + 1, t1);
    write_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP, 32'd40, 4'hF, "timer cmp");
    read_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP, "timer cmp read", d);
    wait_interrupt(1'b1, 1'b1, "timer expiry");
    write_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_CTRL, 32'h0, 4'hF, "timer disable");
    write_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_INTR_STATE, 32'h1, 4'hF, "timer w1c");
    wait_interrupt(1'b1, 1'b0, "timer interrupt clear");
    read_word(soc_pkg::TIMER_BASE + soc_pkg::TIMER_CTRL, "timer ctrl read", d);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    gpio_i  = '0;
    gm_out  = '0;
    gm_dir  = '0;
    gm_in   = '0;
    gm_ien  = '0;
    gm_ist  = '0;
    tm_cmp  = 32'hFFFF_FFFF;
    tm_ctrl = 1'b0;
    repeat (2) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    assert (rvalid_o === 1'b0) else report_mismatch("reset rvalid_o", 0, rvalid_o);
    assert (err_o === 1'b0) else report_mismatch("reset err_o", 0, err_o);
    assert (gpio_en_o === '0) else report_mismatch("reset gpio_en_o", 0, gpio_en_o);
    assert (intr_gpio_o === 1'b0) else report_mismatch("reset intr_gpio_o", 0, intr_gpio_o);
    assert (intr_timer_o === 1'b0) else report_mismatch("reset intr_timer_o", 0, intr_timer_o);
    ram_random_access();
    burst_in_order();
    error_responses();
    gpio_pads_and_intr();
    timer_count_and_intr();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- mini_soc.f
design/soc_pkg.sv
design/bus_decode.sv
design/ram_1p.sv
design/gpio_regs.sv
design/timer_regs.sv
design/resp_mux.sv
design/mini_soc.sv
tb/tb_mini_soc.sv
